/* project.f */
src/cp0_pkg.sv
src/exception_arbiter.sv
src/cp0_regs.sv
src/axil_cp0_port.sv
src/cp0_top.sv
tb/cp0_props.sv
tb/cp0_checker.sv
tb/tb_cp0_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the cp0 testbench with verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/10ps \
   --top-module tb_cp0_top -f project.f -o tb_cp0_top
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/tb_cp0_top +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "TB FAILED" "$LOG"; then
   echo "simulation reported a failure, see $LOG"
   exit 1
fi
echo "simulation finished without failures"
exit 0

/* tb/tb_cp0_top.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_cp0_top import cp0_pkg::*; ();

   logic        clk;
   logic        rst;
   logic        ri;
   logic        brk;
   logic        syscall;
   logic        overflow;
   logic        addr_err_sw;
   logic        addr_err_lw;
   logic        pc_err;
   logic        eret;
   logic        mem_read_en;
   logic        mem_write_en;
   logic        inst_tlb_refill;
   logic        inst_tlb_invalid;
   logic        data_tlb_refill;
   logic        data_tlb_invalid;
   logic        data_tlb_modify;
   logic [31:0] pc_m;
   logic [31:0] mem_addr_m;
   logic [5:0]  hw_int;
   logic [31:0] awaddr;
   logic        awvalid;
   logic        awready;
   logic [31:0] wdata;
   logic [3:0]  wstrb;
   logic        wvalid;
   logic        wready;
   logic [1:0]  bresp;
   logic        bvalid;
   logic        bready;
   logic [31:0] araddr;
   logic        arvalid;
   logic        arready;
   logic [31:0] rdata;
   logic [1:0]  rresp;
   logic        rvalid;
   logic        rready;
   logic [4:0]  except_type;
   logic        flush_exception;
   logic [31:0] pc_exception;

   integer seed = 32'h8583_576f;
   logic   timed_out = 1'b0;
   int     wait_limit = 200;   // cycles per handshake

   cp0_top uut (.*);

   cp0_checker chk (.*);

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   function automatic logic rare_flag();
      return (($random(seed) & 31) == 0);
   endfunction

   function automatic logic [31:0] reg_addr();
      logic [31:0] addr;
      addr = {27'h0, 3'($random(seed)), 2'b00};   // index 5..7 is out of range
      if (($random(seed) & 15) == 0)
         addr[12] = 1'b1;
      return addr;
   endfunction

   task automatic drive_pipeline();
      ri               = rare_flag();
      brk              = rare_flag();
      syscall          = rare_flag();
      overflow         = rare_flag();
      addr_err_sw      = rare_flag();
      addr_err_lw      = rare_flag();
      pc_err           = rare_flag();
      eret             = rare_flag();
      inst_tlb_refill  = rare_flag();
      inst_tlb_invalid = rare_flag();
      data_tlb_refill  = rare_flag();
      data_tlb_invalid = rare_flag();
      data_tlb_modify  = rare_flag();
      mem_read_en      = ($random(seed) & 1) != 0;
      mem_write_en     = ($random(seed) & 1) != 0;
      pc_m             = $random(seed) & 32'hffff_fffc;
      mem_addr_m       = $random(seed);
      hw_int           = rare_flag() ? 6'($random(seed)) : 6'h0;
      bready           = ($random(seed) & 3) != 0;
      rready           = ($random(seed) & 3) != 0;
   endtask

   // pipeline flags and response back-pressure
   initial begin
      ri               = 1'b0;
      brk              = 1'b0;
      syscall          = 1'b0;
      overflow         = 1'b0;
      addr_err_sw      = 1'b0;
      addr_err_lw      = 1'b0;
      pc_err           = 1'b0;
      eret             = 1'b0;
      mem_read_en      = 1'b0;
      mem_write_en     = 1'b0;
      inst_tlb_refill  = 1'b0;
      inst_tlb_invalid = 1'b0;
      data_tlb_refill  = 1'b0;
      data_tlb_invalid = 1'b0;
      data_tlb_modify  = 1'b0;
      pc_m             = 32'h0;
      mem_addr_m       = 32'h0;
      hw_int           = 6'h0;
      bready           = 1'b0;
      rready           = 1'b0;
      forever begin
         @(negedge clk);
         drive_pipeline();
      end
   end

   task automatic host_write(input logic [31:0] addr, input logic [31:0] data);
      int waited;
      waited = 0;
      @(negedge clk);
      awaddr  = addr;
      wdata   = data;
      awvalid = 1'b1;
      wvalid  = 1'b1;
      @(posedge clk);
      while (!awready && !timed_out) begin
         waited++;
         if (waited > wait_limit) begin
            $display("timeout: write to %h not accepted after %0d cycles", addr, wait_limit);
            timed_out = 1'b1;
         end else begin
            @(posedge clk);
         end
      end
      @(negedge clk);
      awvalid = 1'b0;
      wvalid  = 1'b0;
   endtask

   task automatic host_read(input logic [31:0] addr);
      int waited;
      waited = 0;
      @(negedge clk);
      araddr  = addr;
      arvalid = 1'b1;
      @(posedge clk);
      while (!arready && !timed_out) begin
         waited++;
         if (waited > wait_limit) begin
            $display("timeout: read of %h not accepted after %0d cycles", addr, wait_limit);
            timed_out = 1'b1;
         end else begin
            @(posedge clk);
         end
      end
      @(negedge clk);
      arvalid = 1'b0;
   endtask

   task automatic drain_responses();
      int waited;
      waited = 0;
      @(posedge clk);
      while ((bvalid || rvalid) && !timed_out) begin
         waited++;
         if (waited > wait_limit) begin
            $display("timeout: AXI responses never accepted after %0d cycles", wait_limit);
            timed_out = 1'b1;
         end else begin
            @(posedge clk);
         end
      end
   endtask

   initial begin
      int          n;
      int          pick;
      logic [31:0] data;
      awaddr  = 32'h0;
      awvalid = 1'b0;
      wdata   = 32'h0;
      wstrb   = 4'hf;
      wvalid  = 1'b0;
      araddr  = 32'h0;
      arvalid = 1'b0;
      rst     = 1'b1;
      repeat (10) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;

      for (n = 0; (n < 600) && !timed_out; n++) begin
         pick = $random(seed) & 7;
         data = $random(seed);
         case (pick)
            0, 1: host_write(reg_addr(), data);
            2: begin
               data[IE_BIT]  = 1'b1;   // interrupts on, handler left
               data[EXL_BIT] = 1'b0;
               host_write({27'h0, REG_STATUS, 2'b00}, data);
            end
            3: host_write({27'h0, REG_CAUSE, 2'b00}, data);   // software IP bits
            default: host_read(reg_addr());
         endcase
      end
      if (!timed_out)
         drain_responses();
      repeat (4) @(posedge clk);

      $display("cp0 checks: %0d run, %0d mismatches, %0d assertion failures, timeout %0d",
               chk.check_count, chk.err_count, uut.props.fail_count, timed_out);
      if (!timed_out && (chk.err_count == 0) && (uut.props.fail_count == 0))
         $display("TB PASSED");
      else
         $display("TB FAILED");
      $finish;
   end

endmodule

`default_nettype wire

/* tb/cp0_checker.sv */
`timescale 1ns/10ps
`default_nettype none

module cp0_checker import cp0_pkg::*; (
   input wire        clk,
   input wire        rst,
   input wire        ri,
   input wire        brk,
   input wire        syscall,
   input wire        overflow,
   input wire        addr_err_sw,
   input wire        addr_err_lw,
   input wire        pc_err,
   input wire        eret,
   input wire        mem_read_en,
   input wire        mem_write_en,
   input wire        inst_tlb_refill,
   input wire        inst_tlb_invalid,
   input wire        data_tlb_refill,
   input wire        data_tlb_invalid,
   input wire        data_tlb_modify,
   input wire [31:0] pc_m,
   input wire [31:0] mem_addr_m,
   input wire [5:0]  hw_int,
   input wire [31:0] awaddr,
   input wire        awvalid,
   input wire        awready,
   input wire [31:0] wdata,
   input wire        wvalid,
   input wire        wready,
   input wire [1:0]  bresp,
   input wire        bvalid,
   input wire        bready,
   input wire [31:0] araddr,
   input wire        arvalid,
   input wire        arready,
   input wire [31:0] rdata,
   input wire [1:0]  rresp,
   input wire        rvalid,
   input wire        rready,
   input wire [4:0]  except_type,
   input wire        flush_exception,
   input wire [31:0] pc_exception
);

   logic [31:0] m_status;
   logic [31:0] m_cause;
   logic [31:0] m_epc;
   logic [31:0] m_ebase;
   logic [31:0] m_badvaddr;
   logic        m_bvalid;
   logic        m_rvalid;
   logic [1:0]  m_bresp;
   logic [1:0]  m_rresp;
   logic [31:0] m_rdata;
   logic        m_out_of_rst;
   logic [10:0] req;        // index is the priority rank, 0 wins
   logic        refill;
   logic [4:0]  exp_type;
   logic [31:0] exp_pc;
   logic [31:0] exp_bad;
   int          err_count = 0;
   int          check_count = 0;

   function automatic logic [4:0] code_at(input int rank);
      case (rank)
         0:       return EXC_INT;
         1:       return EXC_ADEL;
         2:       return EXC_MOD;
         3:       return EXC_TLBL;
         4:       return EXC_TLBS;
         5:       return EXC_RI;
         6:       return EXC_SYS;
         7:       return EXC_BP;
         8:       return EXC_ADES;
         9:       return EXC_OV;
         default: return EXC_ERET;
      endcase
   endfunction

   function automatic logic in_range(input logic [31:0] addr);
      return (addr[31:5] == 27'h0) && (addr[4:2] <= REG_BADVADDR);
   endfunction

   function automatic logic [31:0] model_reg(input logic [2:0] idx);
      case (idx)
         REG_STATUS: return m_status;
         REG_CAUSE:  return m_cause;
         REG_EPC:    return m_epc;
         REG_EBASE:  return m_ebase;
         default:    return m_badvaddr;
      endcase
   endfunction

   function automatic logic [31:0] masked(input logic [31:0] old, input logic [31:0] val,
                                          input logic [31:0] mask);
      return (old & ~mask) | (val & mask);
   endfunction

   task automatic compare_value(input string what, input logic [31:0] got,
                                input logic [31:0] want);
      check_count++;
      if (got !== want) begin
         err_count++;
         $display("Mismatch at %0t ns: %s is %h, model says %h", $time, what, got, want);
      end
   endtask

   always_comb begin
      req[0]  = m_status[IE_BIT] && !m_status[EXL_BIT] &&
                (|(m_status[IM_HI:IM_LO] & m_cause[IP_HI:IP_LO]));
      req[1]  = addr_err_lw | pc_err;
      req[2]  = data_tlb_modify;
      req[3]  = inst_tlb_refill | inst_tlb_invalid |
                (mem_read_en & (data_tlb_refill | data_tlb_invalid));
      req[4]  = mem_write_en & (data_tlb_refill | data_tlb_invalid);
      req[5]  = ri;
      req[6]  = syscall;
      req[7]  = brk;
      req[8]  = addr_err_sw;
      req[9]  = overflow;
      req[10] = eret;
      exp_type = EXC_NONE;
      for (int r = 10; r >= 0; r--) begin
         if (req[r])
            exp_type = code_at(r);   // lower rank overwrites
      end
      refill = ((exp_type == EXC_TLBL) || (exp_type == EXC_TLBS)) &&
               (inst_tlb_refill | data_tlb_refill);
      if (exp_type == EXC_ERET)
         exp_pc = m_epc;
      else
         exp_pc = (m_status[BEV_BIT] ? BOOT_BASE : m_ebase) + (refill ? 32'h0 : GENERAL_OFFSET);
      exp_bad = (pc_err | inst_tlb_refill | inst_tlb_invalid) ? pc_m : mem_addr_m;
   end

   always @(posedge clk) begin
      logic [4:0]  take;
      logic [31:0] bad;
      logic        wr_hit;
      logic        exp_awready;
      logic        exp_arready;
      if (rst) begin
         m_status          = 32'h0;
         m_status[BEV_BIT] = 1'b1;
         m_cause           = 32'h0;
         m_epc             = 32'h0;
         m_ebase           = RESET_EBASE;
         m_badvaddr        = 32'h0;
         m_bvalid          = 1'b0;
         m_rvalid          = 1'b0;
         m_out_of_rst      = 1'b0;
      end else begin
         // ready stays low in the first cycle after reset
         exp_awready = m_out_of_rst & awvalid & wvalid & ~m_bvalid;
         exp_arready = m_out_of_rst & ~m_rvalid;

         compare_value("except_type", {27'h0, except_type}, {27'h0, exp_type});
         compare_value("flush_exception", {31'h0, flush_exception},
                       {31'h0, exp_type != EXC_NONE});
         compare_value("pc_exception", pc_exception, exp_pc);
         compare_value("bvalid", {31'h0, bvalid}, {31'h0, m_bvalid});
         compare_value("rvalid", {31'h0, rvalid}, {31'h0, m_rvalid});
         compare_value("awready", {31'h0, awready}, {31'h0, exp_awready});
         compare_value("wready", {31'h0, wready}, {31'h0, exp_awready});
         compare_value("arready", {31'h0, arready}, {31'h0, exp_arready});
         if (m_rvalid && rready) begin
            compare_value("rdata", rdata, m_rdata);
            compare_value("rresp", {30'h0, rresp}, {30'h0, m_rresp});
         end
         if (m_bvalid && bready)
            compare_value("bresp", {30'h0, bresp}, {30'h0, m_bresp});

         take   = exp_type;
         bad    = exp_bad;
         wr_hit = exp_awready;

         // read data is what the registers held before this edge
         if (exp_arready && arvalid) begin
            m_rdata  = in_range(araddr) ? model_reg(araddr[4:2]) : 32'h0;
            m_rresp  = in_range(araddr) ? RESP_OKAY : RESP_SLVERR;
            m_rvalid = 1'b1;
         end else if (m_rvalid && rready) begin
            m_rvalid = 1'b0;
         end
         if (wr_hit) begin
            m_bresp  = in_range(awaddr) ? RESP_OKAY : RESP_SLVERR;
            m_bvalid = 1'b1;
         end else if (m_bvalid && bready) begin
            m_bvalid = 1'b0;
         end

         m_cause[IP_HI:IP_LO+2] = hw_int;
         if (wr_hit && in_range(awaddr)) begin
            case (awaddr[4:2])
               REG_STATUS: m_status = masked(m_status, wdata, 32'h0040_ff03);
               REG_CAUSE:  m_cause  = masked(m_cause, wdata, 32'h0000_0300);
               REG_EPC:    m_epc    = wdata;
               REG_EBASE:  m_ebase  = masked(m_ebase, wdata, 32'hffff_f000);
               default:    ;
            endcase
         end

         if (take == EXC_ERET) begin
            m_status[EXL_BIT] = 1'b0;
         end else if (take != EXC_NONE) begin
            m_status[EXL_BIT]      = 1'b1;
            m_cause[EXC_HI:EXC_LO] = take;
            m_epc                  = pc_m;
            if ((take == EXC_ADEL) || (take == EXC_ADES) || (take == EXC_MOD) ||
                (take == EXC_TLBL) || (take == EXC_TLBS))
               m_badvaddr = bad;
         end
         m_out_of_rst = 1'b1;
      end
   end

endmodule

`default_nettype wire

/* tb/cp0_props.sv */
`timescale 1ns/10ps
`default_nettype none

module cp0_props import cp0_pkg::*; (
   input wire        clk,
   input wire        rst,
   input wire        bvalid,
   input wire        bready,
   input wire        rvalid,
   input wire        rready,
   input wire [31:0] rdata,
   input wire [1:0]  rresp,
   input wire        flush_exception,
   input wire [4:0]  except_type
);

   int fail_count = 0;   // read by the testbench verdict

   b_held: assert property (@(posedge clk) disable iff (rst)
      bvalid && !bready |=> bvalid)
      else begin
         fail_count++;
         $error("bvalid dropped before bready");
      end

   r_held: assert property (@(posedge clk) disable iff (rst)
      rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
      else begin
         fail_count++;
         $error("read response changed before rready");
      end

   flush_match: assert property (@(posedge clk) disable iff (rst)
      flush_exception == (except_type != EXC_NONE))
      else begin
         fail_count++;
         $error("flush_exception disagrees with except_type");
      end

endmodule

bind cp0_top cp0_props props (
   .clk             (clk),
   .rst             (rst),
   .bvalid          (bvalid),
   .bready          (bready),
   .rvalid          (rvalid),
   .rready          (rready),
   .rdata           (rdata),
   .rresp           (rresp),
   .flush_exception (flush_exception),
   .except_type     (except_type)
);

`default_nettype wire

/* src/cp0_top.sv */
`timescale 1ns/10ps
`default_nettype none

module cp0_top (
   input  wire         clk,
   input  wire         rst,
   input  wire         ri,
   input  wire         brk,
   input  wire         syscall,
   input  wire         overflow,
   input  wire         addr_err_sw,
   input  wire         addr_err_lw,
   input  wire         pc_err,
   input  wire         eret,
   input  wire         mem_read_en,
   input  wire         mem_write_en,
   input  wire         inst_tlb_refill,
   input  wire         inst_tlb_invalid,
   input  wire         data_tlb_refill,
   input  wire         data_tlb_invalid,
   input  wire         data_tlb_modify,
   input  wire  [31:0] pc_m,
   input  wire  [31:0] mem_addr_m,
   input  wire  [5:0]  hw_int,
   input  wire  [31:0] awaddr,
   input  wire         awvalid,
   output logic        awready,
   input  wire  [31:0] wdata,
   input  wire  [3:0]  wstrb,
   input  wire         wvalid,
   output logic        wready,
   output logic [1:0]  bresp,
   output logic        bvalid,
   input  wire         bready,
   input  wire  [31:0] araddr,
   input  wire         arvalid,
   output logic        arready,
   output logic [31:0] rdata,
   output logic [1:0]  rresp,
   output logic        rvalid,
   input  wire         rready,
   output logic [4:0]  except_type,
   output logic        flush_exception,
   output logic [31:0] pc_exception
);

   logic        reg_wr_en;
   logic [2:0]  reg_wr_idx;
   logic [31:0] reg_wr_data;
   logic [2:0]  reg_rd_idx;
   logic [31:0] reg_rd_data;
   logic [31:0] status;
   logic [31:0] cause;
   logic [31:0] epc;
   logic [31:0] ebase;
   logic [31:0] bad_vaddr;

   axil_cp0_port u_port (
      .clk         (clk),
      .rst         (rst),
      .awaddr      (awaddr),
      .awvalid     (awvalid),
      .awready     (awready),
      .wdata       (wdata),
      .wstrb       (wstrb),
      .wvalid      (wvalid),
      .wready      (wready),
      .bresp       (bresp),
      .bvalid      (bvalid),
      .bready      (bready),
      .araddr      (araddr),
      .arvalid     (arvalid),
      .arready     (arready),
      .rdata       (rdata),
      .rresp       (rresp),
      .rvalid      (rvalid),
      .rready      (rready),
      .reg_wr_en   (reg_wr_en),
      .reg_wr_idx  (reg_wr_idx),
      .reg_wr_data (reg_wr_data),
      .reg_rd_idx  (reg_rd_idx),
      .reg_rd_data (reg_rd_data)
   );

   cp0_regs u_regs (
      .clk             (clk),
      .rst             (rst),
      .reg_wr_en       (reg_wr_en),
      .reg_wr_idx      (reg_wr_idx),
      .reg_wr_data     (reg_wr_data),
      .reg_rd_idx      (reg_rd_idx),
      .hw_int          (hw_int),
      .except_type     (except_type),
      .flush_exception (flush_exception),
      .bad_vaddr       (bad_vaddr),
      .pc_m            (pc_m),
      .reg_rd_data     (reg_rd_data),
      .status          (status),
      .cause           (cause),
      .epc             (epc),
      .ebase           (ebase)
   );

   exception_arbiter u_arb (
      .ri               (ri),
      .brk              (brk),
      .syscall          (syscall),
      .overflow         (overflow),
      .addr_err_sw      (addr_err_sw),
      .addr_err_lw      (addr_err_lw),
      .pc_err           (pc_err),
      .eret             (eret),
      .mem_read_en      (mem_read_en),
      .mem_write_en     (mem_write_en),
      .inst_tlb_refill  (inst_tlb_refill),
      .inst_tlb_invalid (inst_tlb_invalid),
      .data_tlb_refill  (data_tlb_refill),
      .data_tlb_invalid (data_tlb_invalid),
      .data_tlb_modify  (data_tlb_modify),
      .status           (status),
      .cause            (cause),
      .epc              (epc),
      .ebase            (ebase),
      .pc_m             (pc_m),
      .mem_addr_m       (mem_addr_m),
      .except_type      (except_type),
      .flush_exception  (flush_exception),
      .pc_exception     (pc_exception),
      .bad_vaddr        (bad_vaddr)
   );

endmodule

`default_nettype wire

/* src/axil_cp0_port.sv */
`timescale 1ns/10ps
`default_nettype none

module axil_cp0_port import cp0_pkg::*; (
   input  wire         clk,
   input  wire         rst,
   input  wire  [31:0] awaddr,
   input  wire         awvalid,
   output logic        awready,
   input  wire  [31:0] wdata,
   input  wire  [3:0]  wstrb,       // full-word writes only, not decoded
   input  wire         wvalid,
   output logic        wready,
   output logic [1:0]  bresp,
   output logic        bvalid,
   input  wire         bready,
   input  wire  [31:0] araddr,
   input  wire         arvalid,
   output logic        arready,
   output logic [31:0] rdata,
   output logic [1:0]  rresp,
   output logic        rvalid,
   input  wire         rready,
   output logic        reg_wr_en,
   output logic [2:0]  reg_wr_idx,
   output logic [31:0] reg_wr_data,
   output logic [2:0]  reg_rd_idx,
   input  wire  [31:0] reg_rd_data
);

   logic wr_idle;
   logic wr_fire;
   logic wr_ok;
   logic rd_ok;

   // only word indices 0..4 exist
   assign wr_ok = (awaddr[31:5] == 27'h0) && (awaddr[4:2] <= REG_BADVADDR);
   assign rd_ok = (araddr[31:5] == 27'h0) && (araddr[4:2] <= REG_BADVADDR);

   assign wr_fire = awvalid && wvalid && wr_idle;
   assign awready = wr_fire;
   assign wready  = wr_fire;

   assign reg_wr_en   = wr_fire && wr_ok;
   assign reg_wr_idx  = awaddr[4:2];
   assign reg_wr_data = wdata;
   assign reg_rd_idx  = araddr[4:2];

   always_ff @(posedge clk) begin
      if (rst) begin
         bvalid  <= 1'b0;
         wr_idle <= 1'b0;
      end else if (wr_fire) begin
         bvalid  <= 1'b1;
         wr_idle <= 1'b0;
         bresp   <= wr_ok ? RESP_OKAY : RESP_SLVERR;
      end else if (bvalid && bready) begin
         bvalid  <= 1'b0;
         wr_idle <= 1'b1;
      end else begin
         wr_idle <= !bvalid;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         rvalid  <= 1'b0;
         arready <= 1'b0;
      end else if (arvalid && arready) begin
         rvalid  <= 1'b1;
         arready <= 1'b0;
         rdata   <= rd_ok ? reg_rd_data : 32'h0;
         rresp   <= rd_ok ? RESP_OKAY : RESP_SLVERR;
      end else if (rvalid && rready) begin
         rvalid  <= 1'b0;
         arready <= 1'b1;
      end else begin
         arready <= !rvalid;   // held low while a response waits
      end
   end

endmodule

`default_nettype wire

/* src/cp0_regs.sv */
`timescale 1ns/10ps
`default_nettype none

module cp0_regs import cp0_pkg::*; (
   input  wire         clk,
   input  wire         rst,
   input  wire         reg_wr_en,
   input  wire  [2:0]  reg_wr_idx,
   input  wire  [31:0] reg_wr_data,
   input  wire  [2:0]  reg_rd_idx,
   input  wire  [5:0]  hw_int,
   input  wire  [4:0]  except_type,
   input  wire         flush_exception,
   input  wire  [31:0] bad_vaddr,
   input  wire  [31:0] pc_m,
   output logic [31:0] reg_rd_data,
   output logic [31:0] status,
   output logic [31:0] cause,
   output logic [31:0] epc,
   output logic [31:0] ebase
);

   logic [31:0] badvaddr_q;
   logic        addr_fault;
   logic        take_exc;
   logic        take_eret;

   // address errors and all tlb faults latch the faulting address
   assign addr_fault = (except_type == EXC_ADEL) || (except_type == EXC_ADES) ||
                       (except_type == EXC_MOD)  || (except_type == EXC_TLBL) ||
                       (except_type == EXC_TLBS);

   assign take_eret = flush_exception && (except_type == EXC_ERET);
   assign take_exc  = flush_exception && (except_type != EXC_ERET);

   always_ff @(posedge clk) begin
      if (rst) begin
         status     <= 32'd1 << BEV_BIT;   // boot vectors out of reset
         cause      <= 32'h0;
         epc        <= 32'h0;
         ebase      <= RESET_EBASE;
         badvaddr_q <= 32'h0;
      end else begin
         cause[IP_HI:IP_LO+2] <= hw_int;   // sampled every cycle

         // host write first, commit below overrides its own fields
         if (reg_wr_en) begin
            case (reg_wr_idx)
               REG_STATUS: begin
                  status[IE_BIT]      <= reg_wr_data[IE_BIT];
                  status[EXL_BIT]     <= reg_wr_data[EXL_BIT];
                  status[IM_HI:IM_LO] <= reg_wr_data[IM_HI:IM_LO];
                  status[BEV_BIT]     <= reg_wr_data[BEV_BIT];
               end
               REG_CAUSE:
                  cause[IP_LO+1:IP_LO] <= reg_wr_data[IP_LO+1:IP_LO];   // sw bits only
               REG_EPC:
                  epc <= reg_wr_data;
               REG_EBASE:
                  ebase[31:12] <= reg_wr_data[31:12];   // 4K aligned
               default: ;   // badvaddr read-only
            endcase
         end

         if (take_exc) begin
            status[EXL_BIT]      <= 1'b1;
            cause[EXC_HI:EXC_LO] <= except_type;
            epc                  <= pc_m;
            if (addr_fault)
               badvaddr_q <= bad_vaddr;
         end else if (take_eret) begin
            status[EXL_BIT] <= 1'b0;
         end
      end
   end

   always_comb begin
      case (reg_rd_idx)
         REG_STATUS:   reg_rd_data = status;
         REG_CAUSE:    reg_rd_data = cause;
         REG_EPC:      reg_rd_data = epc;
         REG_EBASE:    reg_rd_data = ebase;
         REG_BADVADDR: reg_rd_data = badvaddr_q;
         default:      reg_rd_data = 32'h0;
      endcase
   end

endmodule

`default_nettype wire

/* src/exception_arbiter.sv */
`timescale 1ns/10ps
`default_nettype none

module exception_arbiter import cp0_pkg::*; (
   input  wire        ri,
   input  wire        brk,
   input  wire        syscall,
   input  wire        overflow,
   input  wire        addr_err_sw,
   input  wire        addr_err_lw,
   input  wire        pc_err,
   input  wire        eret,
   input  wire        mem_read_en,
   input  wire        mem_write_en,
   input  wire        inst_tlb_refill,
   input  wire        inst_tlb_invalid,
   input  wire        data_tlb_refill,
   input  wire        data_tlb_invalid,
   input  wire        data_tlb_modify,
   input  wire [31:0] status,
   input  wire [31:0] cause,
   input  wire [31:0] epc,
   input  wire [31:0] ebase,
   input  wire [31:0] pc_m,
   input  wire [31:0] mem_addr_m,
   output logic [4:0] except_type,
   output logic       flush_exception,
   output logic [31:0] pc_exception,
   output logic [31:0] bad_vaddr
);

   logic        int_pending;
   logic        tlb_load;
   logic        tlb_store;
   logic        refill_taken;
   logic [31:0] vec_base;
   logic [31:0] vec_offset;

   // enabled, not inside a handler, some unmasked request
   assign int_pending = status[IE_BIT] && !status[EXL_BIT] &&
                        (|(status[IM_HI:IM_LO] & cause[IP_HI:IP_LO]));

   assign tlb_load  = inst_tlb_refill | inst_tlb_invalid |
                      (mem_read_en & (data_tlb_refill | data_tlb_invalid));
   assign tlb_store = mem_write_en & (data_tlb_refill | data_tlb_invalid);

   always_comb begin
      if (int_pending)
         except_type = EXC_INT;
      else if (addr_err_lw | pc_err)
         except_type = EXC_ADEL;
      else if (data_tlb_modify)
         except_type = EXC_MOD;
      else if (tlb_load)
         except_type = EXC_TLBL;
      else if (tlb_store)
         except_type = EXC_TLBS;
      else if (ri)
         except_type = EXC_RI;
      else if (syscall)
         except_type = EXC_SYS;
      else if (brk)
         except_type = EXC_BP;
      else if (addr_err_sw)
         except_type = EXC_ADES;
      else if (overflow)
         except_type = EXC_OV;
      else if (eret)
         except_type = EXC_ERET;
      else
         except_type = EXC_NONE;
   end

   assign flush_exception = (except_type != EXC_NONE);

   // refill faults use the base vector itself
   assign refill_taken = ((except_type == EXC_TLBL) || (except_type == EXC_TLBS)) &&
                         (inst_tlb_refill | data_tlb_refill);

   assign vec_base     = status[BEV_BIT] ? BOOT_BASE : ebase;
   assign vec_offset   = refill_taken ? 32'h0 : GENERAL_OFFSET;
   assign pc_exception = (except_type == EXC_ERET) ? epc : vec_base + vec_offset;

   assign bad_vaddr = (pc_err | inst_tlb_refill | inst_tlb_invalid) ? pc_m : mem_addr_m;

endmodule

`default_nettype wire

/* src/cp0_pkg.sv */
`default_nettype none

package cp0_pkg;

   // cp0 register index, host address bits 4:2
   localparam logic [2:0] REG_STATUS   = 3'd0;
   localparam logic [2:0] REG_CAUSE    = 3'd1;
   localparam logic [2:0] REG_EPC      = 3'd2;
   localparam logic [2:0] REG_EBASE    = 3'd3;
   localparam logic [2:0] REG_BADVADDR = 3'd4;

   // status fields
   localparam int IE_BIT  = 0;
   localparam int EXL_BIT = 1;
   localparam int IM_LO   = 8;
   localparam int IM_HI   = 15;
   localparam int BEV_BIT = 22;

   // cause fields, ip1..ip0 software, ip7..ip2 hardware
   localparam int IP_LO  = 8;
   localparam int IP_HI  = 15;
   localparam int EXC_LO = 2;
   localparam int EXC_HI = 6;

   localparam logic [4:0] EXC_INT  = 5'd0;
   localparam logic [4:0] EXC_MOD  = 5'd1;
   localparam logic [4:0] EXC_TLBL = 5'd2;
   localparam logic [4:0] EXC_TLBS = 5'd3;
   localparam logic [4:0] EXC_ADEL = 5'd4;
   localparam logic [4:0] EXC_ADES = 5'd5;
   localparam logic [4:0] EXC_SYS  = 5'd8;
   localparam logic [4:0] EXC_BP   = 5'd9;
   localparam logic [4:0] EXC_RI   = 5'd10;
   localparam logic [4:0] EXC_OV   = 5'd12;
   localparam logic [4:0] EXC_ERET = 5'd14;
   localparam logic [4:0] EXC_NONE = 5'd31;   // nothing to take

   localparam logic [31:0] BOOT_BASE      = 32'hbfc0_0200;
   localparam logic [31:0] GENERAL_OFFSET = 32'h0000_0180;
   localparam logic [31:0] RESET_EBASE    = 32'h8000_0000;

   localparam logic [1:0] RESP_OKAY   = 2'b00;
   localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

`default_nettype wire
